// ==== src/cmd_pkg.sv ====
package cmd_pkg;

    // Host command opcodes, one per queue entry
    typedef enum logic [2:0] {
        OP_NOP         = 3'd0,
        OP_LOAD_BASE   = 3'd1, // Page table base from data[2:0]
        OP_LOAD_MAR_HI = 3'd2,
        OP_LOAD_MAR_LO = 3'd3,
        OP_INC_MAR     = 3'd4,
        OP_WRITE_PTE   = 3'd5, // Entry at current page index
        OP_WRITE       = 3'd6, // Bus write at translated address
        OP_READ        = 3'd7
    } op_e;

    // Width of the data byte carried with each command
    localparam int CMD_DATA_W = 8;

endpackage

// ==== src/mmu_pkg.sv ====
package mmu_pkg;

    localparam int LOG_ADDR_W    = 16;
    localparam int PHYS_ADDR_W   = 19;
    localparam int PAGE_OFFSET_W = 11; // Passed through translation untouched
    localparam int BASE_W        = 3;

    // Page number bits of the logical address
    localparam int LOG_PAGE_W  = LOG_ADDR_W - PAGE_OFFSET_W;
    localparam int PHYS_PAGE_W = PHYS_ADDR_W - PAGE_OFFSET_W;

    typedef logic [LOG_ADDR_W-1:0] log_addr_t;
    typedef logic [PHYS_ADDR_W-1:0] phys_addr_t;

    // Logical bits 15:11 followed by the base
    typedef logic [LOG_PAGE_W+BASE_W-1:0] page_index_t;

    // Physical bits 18:11
    typedef logic [PHYS_PAGE_W-1:0] pte_t;

    // What the translated address points at
    typedef enum logic [1:0] {
        REGION_MEMORY   = 2'd0,
        REGION_REGISTER = 2'd1,
        REGION_BAD_PAGE = 2'd2
    } region_e;

endpackage

// ==== src/cmd_queue.sv ====
`timescale 1ns/100ps

module cmd_queue import cmd_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  op_e                   cmd_op,
    input  logic [CMD_DATA_W-1:0] cmd_data,
    input  logic                  q_pop,
    output logic                  q_valid,
    output op_e                   q_op,
    output logic [CMD_DATA_W-1:0] q_data,
    output logic                  credit_return
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    // Entry storage
    op_e                   op_mem [QUEUE_DEPTH];
    logic [CMD_DATA_W-1:0] data_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full    = (count == CNT_W'(QUEUE_DEPTH));
    assign q_valid = (count != '0);
    assign q_op    = op_mem[rd_ptr];
    assign q_data  = data_mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (cmd_valid) begin
            op_mem[wr_ptr]   <= cmd_op;
            data_mem[wr_ptr] <= cmd_data;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (q_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, q_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            credit_return <= q_pop; // One credit back per command handed on
        end
    end

    // Host spent a credit it did not hold
    a_no_push_when_full: assert property (
        @(posedge clock) disable iff (reset) !(cmd_valid && full)
    );

    // Sequencer must only pop what the queue shows
    a_no_pop_when_empty: assert property (
        @(posedge clock) disable iff (reset) q_pop |-> q_valid
    );

endmodule

// ==== src/page_translator.sv ====
`timescale 1ns/100ps

module page_translator import mmu_pkg::*; (
    input  logic              clock,
    input  log_addr_t         mar,
    input  logic [BASE_W-1:0] page_base,
    input  logic              pte_we,
    input  pte_t              pte_data,
    output phys_addr_t        phys_addr,
    output region_e           region
);

    localparam int TABLE_SIZE = 2 ** $bits(page_index_t);

    // 256 x 8 page table, contents set by software after reset
    pte_t page_table [TABLE_SIZE];

    page_index_t page_index;
    pte_t        pte_out;
    logic        bad_page;
    logic        reg_space;

    assign page_index = {mar[LOG_ADDR_W-1:PAGE_OFFSET_W], page_base};
    assign pte_out    = page_table[page_index];

    always_ff @(posedge clock) begin
        if (pte_we) begin
            page_table[page_index] <= pte_data;
        end
    end

    // Entry supplies the page, offset passes straight through
    assign phys_addr = {pte_out, mar[PAGE_OFFSET_W-1:0]};

    // Top of the physical space with bit 11 set is unmapped
    assign bad_page  = (&phys_addr[18:13]) && phys_addr[11];

    // Lowest 256 bytes are the register file
    assign reg_space = (phys_addr[18:8] == '0);

    always_comb begin
        if (bad_page) begin
            region = REGION_BAD_PAGE;
        end else if (reg_space) begin
            region = REGION_REGISTER;
        end else begin
            region = REGION_MEMORY;
        end
    end

endmodule

// ==== src/access_sequencer.sv ====
`timescale 1ns/100ps

module access_sequencer import cmd_pkg::*, mmu_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  q_valid,
    input  op_e                   q_op,
    input  logic [CMD_DATA_W-1:0] q_data,
    output logic                  q_pop,
    output log_addr_t             mar,
    output logic [BASE_W-1:0]     page_base,
    output logic                  pte_we,
    output pte_t                  pte_data,
    output logic                  wr_strobe,
    output logic [CMD_DATA_W-1:0] wr_data,
    output logic                  rd_strobe
);

    // Never stalls, so the head goes every cycle it is there
    assign q_pop = q_valid;

    // Payload rides along with the strobes
    assign pte_data = pte_t'(q_data);
    assign wr_data  = q_data;

    // Strobe decode
    always_comb begin
        pte_we    = 1'b0;
        wr_strobe = 1'b0;
        rd_strobe = 1'b0;
        if (q_valid) begin
            case (q_op)
                OP_WRITE_PTE: pte_we    = 1'b1;
                OP_WRITE:     wr_strobe = 1'b1;
                OP_READ:      rd_strobe = 1'b1;
                default:      ; // Register updates only
            endcase
        end
    end

    // Address and base registers
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mar       <= '0;
            page_base <= '0;
        end else if (q_valid) begin
            case (q_op)
                OP_LOAD_BASE: begin
                    page_base <= q_data[BASE_W-1:0];
                end
                OP_LOAD_MAR_HI: begin
                    mar[15:8] <= q_data;
                end
                OP_LOAD_MAR_LO: begin
                    mar[7:0] <= q_data;
                end
                OP_INC_MAR: begin
                    mar <= mar + 1'b1; // May carry into the next page
                end
                default: begin
                    mar       <= mar;
                    page_base <= page_base;
                end
            endcase
        end
    end

    // One access kind per cycle into translator and bus port
    a_one_strobe: assert property (
        @(posedge clock) disable iff (reset) $onehot0({pte_we, wr_strobe, rd_strobe})
    );

endmodule

// ==== src/bus_port.sv ====
`timescale 1ns/100ps

module bus_port import mmu_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       wr_strobe,
    input  logic [7:0] wr_data,
    input  logic       rd_strobe,
    input  region_e    region,
    input  logic [7:0] bus_data_in,
    output logic       bus_we,
    output logic [7:0] bus_data_out,
    output logic       rd_valid,
    output logic [7:0] rd_data
);

    logic wr_pending;  // Set with the data register
    logic wr_delayed;

    // Write data register, also the register-space read source
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_data_out <= '0;
        end else if (wr_strobe) begin
            bus_data_out <= wr_data;
        end
    end

    // Enable trails the data by two clocks
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_pending <= 1'b0;
            wr_delayed <= 1'b0;
            bus_we     <= 1'b0;
            rd_valid   <= 1'b0;
        end else begin
            wr_pending <= wr_strobe;
            wr_delayed <= wr_pending;
            bus_we     <= wr_delayed;
            rd_valid   <= rd_strobe;
        end
    end

    // Register space returns the last byte written instead of the bus
    always_ff @(posedge clock) begin
        if (rd_strobe) begin
            if (region == REGION_REGISTER) begin
                rd_data <= bus_data_out;
            end else begin
                rd_data <= bus_data_in;
            end
        end
    end

    // Back-to-back enables need back-to-back writes three clocks earlier
    a_we_pairs: assert property (
        @(posedge clock) disable iff (reset)
        (bus_we && $past(bus_we)) |-> ($past(wr_strobe, 3) && $past(wr_strobe, 4))
    );

endmodule

// ==== src/cpu6_mmu.sv ====
`timescale 1ns/100ps

module cpu6_mmu import cmd_pkg::*, mmu_pkg::*; #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  cmd_valid,
    input  op_e                   cmd_op,
    input  logic [CMD_DATA_W-1:0] cmd_data,
    input  logic [7:0]            bus_data_in,
    output logic                  credit_return,
    output phys_addr_t            bus_addr,
    output region_e               bus_region,
    output logic                  bus_we,
    output logic [7:0]            bus_data_out,
    output logic                  rd_valid,
    output logic [7:0]            rd_data
);

    // Queue head
    logic                  q_valid;
    op_e                   q_op;
    logic [CMD_DATA_W-1:0] q_data;
    logic                  q_pop;

    // Sequencer to translator and bus port
    log_addr_t             mar;
    logic [BASE_W-1:0]     page_base;
    logic                  pte_we;
    pte_t                  pte_data;
    logic                  wr_strobe;
    logic [CMD_DATA_W-1:0] wr_data;
    logic                  rd_strobe;

    cmd_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_queue (
        .clock         (clock),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_data      (cmd_data),
        .q_pop         (q_pop),
        .q_valid       (q_valid),
        .q_op          (q_op),
        .q_data        (q_data),
        .credit_return (credit_return)
    );

    access_sequencer i_sequencer (
        .clock     (clock),
        .reset     (reset),
        .q_valid   (q_valid),
        .q_op      (q_op),
        .q_data    (q_data),
        .q_pop     (q_pop),
        .mar       (mar),
        .page_base (page_base),
        .pte_we    (pte_we),
        .pte_data  (pte_data),
        .wr_strobe (wr_strobe),
        .wr_data   (wr_data),
        .rd_strobe (rd_strobe)
    );

    page_translator i_translator (
        .clock     (clock),
        .mar       (mar),
        .page_base (page_base),
        .pte_we    (pte_we),
        .pte_data  (pte_data),
        .phys_addr (bus_addr),
        .region    (bus_region)
    );

    bus_port i_bus_port (
        .clock        (clock),
        .reset        (reset),
        .wr_strobe    (wr_strobe),
        .wr_data      (wr_data),
        .rd_strobe    (rd_strobe),
        .region       (bus_region),
        .bus_data_in  (bus_data_in),
        .bus_we       (bus_we),
        .bus_data_out (bus_data_out),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

endmodule

// ==== include/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// Each row is one host command and the results it should produce
// Region and byte are checked on writes, the byte alone on reads
typedef struct {
    string      name;
    op_e        op;
    logic [7:0] data;
    logic       rnd_pte;  // Data replaced by an LFSR page entry
    region_e    region;
    logic [7:0] exp_byte;
} vec_t;

localparam int NUM_VECTORS = 42;

vec_t vectors [NUM_VECTORS] = '{
    '{"base_zero",   OP_LOAD_BASE,   8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"mar_hi_p1",   OP_LOAD_MAR_HI, 8'h08, 1'b0, REGION_MEMORY,   8'h00},
    '{"mar_lo_p1",   OP_LOAD_MAR_LO, 8'h34, 1'b0, REGION_MEMORY,   8'h00},
    '{"pte_p1_b0",   OP_WRITE_PTE,   8'h00, 1'b1, REGION_MEMORY,   8'h00},
    '{"wr_p1_b0",    OP_WRITE,       8'ha5, 1'b0, REGION_MEMORY,   8'ha5},
    '{"rd_p1_b0",    OP_READ,        8'h00, 1'b0, REGION_MEMORY,   8'hcb},
    '{"nop_a",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    // Same page under a second base
    '{"base_five",   OP_LOAD_BASE,   8'h05, 1'b0, REGION_MEMORY,   8'h00},
    '{"pte_p1_b5",   OP_WRITE_PTE,   8'h00, 1'b1, REGION_MEMORY,   8'h00},
    '{"wr_p1_b5",    OP_WRITE,       8'h5a, 1'b0, REGION_MEMORY,   8'h5a},
    '{"nop_b",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"nop_c",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"base_zero_2", OP_LOAD_BASE,   8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"wr_p1_b0_2",  OP_WRITE,       8'h3c, 1'b0, REGION_MEMORY,   8'h3c},
    '{"rd_p1_b0_2",  OP_READ,        8'h00, 1'b0, REGION_MEMORY,   8'hcb},
    '{"nop_d",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    // Zero entry and small offset land in register space
    '{"mar_hi_reg",  OP_LOAD_MAR_HI, 8'h10, 1'b0, REGION_MEMORY,   8'h00},
    '{"mar_lo_reg",  OP_LOAD_MAR_LO, 8'h7f, 1'b0, REGION_MEMORY,   8'h00},
    '{"pte_reg",     OP_WRITE_PTE,   8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"wr_reg",      OP_WRITE,       8'he7, 1'b0, REGION_REGISTER, 8'he7},
    '{"rd_reg",      OP_READ,        8'h00, 1'b0, REGION_REGISTER, 8'he7},
    '{"nop_e",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    // Page 4 entry set ahead of the carry
    '{"mar_hi_p4",   OP_LOAD_MAR_HI, 8'h20, 1'b0, REGION_MEMORY,   8'h00},
    '{"pte_p4",      OP_WRITE_PTE,   8'h00, 1'b1, REGION_MEMORY,   8'h00},
    '{"mar_hi_bad",  OP_LOAD_MAR_HI, 8'h1f, 1'b0, REGION_MEMORY,   8'h00},
    '{"mar_lo_bad",  OP_LOAD_MAR_LO, 8'hff, 1'b0, REGION_MEMORY,   8'h00},
    '{"pte_bad",     OP_WRITE_PTE,   8'hfd, 1'b0, REGION_MEMORY,   8'h00},
    '{"wr_bad",      OP_WRITE,       8'h96, 1'b0, REGION_BAD_PAGE, 8'h96},
    '{"rd_bad",      OP_READ,        8'h00, 1'b0, REGION_BAD_PAGE, 8'h00},
    '{"nop_f",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"inc_carry",   OP_INC_MAR,     8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"wr_p4",       OP_WRITE,       8'h0f, 1'b0, REGION_MEMORY,   8'h0f},
    '{"rd_p4",       OP_READ,        8'h00, 1'b0, REGION_MEMORY,   8'hff},
    '{"nop_g",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    // Back-to-back burst
    '{"burst_inc_0", OP_INC_MAR,     8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"burst_inc_1", OP_INC_MAR,     8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"burst_inc_2", OP_INC_MAR,     8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"burst_inc_3", OP_INC_MAR,     8'h00, 1'b0, REGION_MEMORY,   8'h00},
    '{"wr_burst_a",  OP_WRITE,       8'h81, 1'b0, REGION_MEMORY,   8'h81},
    '{"rd_burst",    OP_READ,        8'h00, 1'b0, REGION_MEMORY,   8'hfb},
    '{"nop_h",       OP_NOP,         8'h00, 1'b0, REGION_MEMORY,   8'h00},
    // Later write kept clear of the earlier enable
    '{"wr_burst_b",  OP_WRITE,       8'h42, 1'b0, REGION_MEMORY,   8'h42}
};

`endif

// ==== tests/tb_cpu6_mmu.sv ====
`timescale 1ns/100ps

module tb_cpu6_mmu import cmd_pkg::*, mmu_pkg::*;;

    localparam int QUEUE_DEPTH = 4;

    `include "tb_vectors.svh"

    localparam int TIMEOUT_CYCLES = NUM_VECTORS * (QUEUE_DEPTH + 4) + 100;

    typedef struct {
        string      name;
        phys_addr_t addr;
        region_e    region;
        logic [7:0] data;
    } write_exp_t;

    typedef struct {
        string      name;
        logic [7:0] data;
    } read_exp_t;

    logic                  clock = 1'b0;
    logic                  reset;
    logic                  cmd_valid;
    op_e                   cmd_op;
    logic [CMD_DATA_W-1:0] cmd_data;
    logic [7:0]            bus_data_in;
    logic                  credit_return;
    phys_addr_t            bus_addr;
    region_e               bus_region;
    logic                  bus_we;
    logic [7:0]            bus_data_out;
    logic                  rd_valid;
    logic [7:0]            rd_data;

    // Reference state, updated in command order
    pte_t              model_table [256];
    log_addr_t         model_mar  = '0;
    logic [BASE_W-1:0] model_base = '0;

    write_exp_t  write_q [$];
    read_exp_t   read_q [$];
    logic [31:0] lfsr_state  = 32'h4c5b_f472;
    int          credits     = 0;
    int          sent        = 0;
    int          returned    = 0;
    int          cycle_count = 0;

    always #4 clock = ~clock;

    // Bus memory model returns the inverted low address byte
    assign bus_data_in = ~bus_addr[7:0];

    cpu6_mmu #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) i_dut (
        .clock         (clock),
        .reset         (reset),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_data      (cmd_data),
        .bus_data_in   (bus_data_in),
        .credit_return (credit_return),
        .bus_addr      (bus_addr),
        .bus_region    (bus_region),
        .bus_we        (bus_we),
        .bus_data_out  (bus_data_out),
        .rd_valid      (rd_valid),
        .rd_data       (rd_data)
    );

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_addr(input string name, input phys_addr_t exp, input phys_addr_t act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected addr 0x%05h, actual 0x%05h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_region(input string name, input region_e exp, input region_e act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected region %s, actual %s (%0d)",
                     name, exp.name(), act.name(), act);
            stop_on_failure();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected byte 0x%02h, actual 0x%02h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic expect_low(input string name, input logic act);
        if (act !== 1'b0) begin
            $display("MISMATCH %s: expected 0, actual %b", name, act);
            stop_on_failure();
        end
    endtask

    task automatic compare_credits(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("MISMATCH %s: expected %0d credits, actual %0d", name, exp, act);
            stop_on_failure();
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // Bit 7 low and bit 6 high keep the entry in ordinary memory
    task automatic random_pte(output logic [7:0] value);
        value = 8'b0100_0000;
        for (int b = 0; b < 6; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value[b]   = lfsr_state[0];
        end
    endtask

    task automatic apply_model(input int row, input logic [7:0] value);
        page_index_t idx;
        write_exp_t  w;
        read_exp_t   r;
        idx = {model_mar[LOG_ADDR_W-1:PAGE_OFFSET_W], model_base};
        case (vectors[row].op)
            OP_LOAD_BASE:   model_base = value[BASE_W-1:0];
            OP_LOAD_MAR_HI: model_mar[15:8] = value;
            OP_LOAD_MAR_LO: model_mar[7:0] = value;
            OP_INC_MAR:     model_mar = model_mar + 1'b1;
            OP_WRITE_PTE:   model_table[idx] = value;
            OP_WRITE: begin
                w.name   = vectors[row].name;
                w.addr   = {model_table[idx], model_mar[PAGE_OFFSET_W-1:0]}; // Entry then offset
                w.region = vectors[row].region;
                w.data   = vectors[row].exp_byte;
                write_q.push_back(w);
            end
            OP_READ: begin
                r.name = vectors[row].name;
                r.data = vectors[row].exp_byte;
                read_q.push_back(r);
            end
            default: ;
        endcase
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clock) begin
        write_exp_t w;
        read_exp_t  r;
        if (!reset) begin
            if (credit_return) begin
                credits  = credits + 1;
                returned = returned + 1;
                if (credits > QUEUE_DEPTH) begin
                    $display("ERROR: a credit came back with no command outstanding");
                    stop_on_failure();
                end
            end
            if (bus_we) begin
                if (write_q.size() == 0) begin
                    $display("ERROR: bus_we pulsed with no write outstanding");
                    stop_on_failure();
                end else begin
                    w = write_q.pop_front();
                    check_addr(w.name, w.addr, bus_addr);
                    check_region(w.name, w.region, bus_region);
                    check_byte(w.name, w.data, bus_data_out);
                end
            end
            if (rd_valid) begin
                if (read_q.size() == 0) begin
                    $display("ERROR: rd_valid pulsed with no read outstanding");
                    stop_on_failure();
                end else begin
                    r = read_q.pop_front();
                    check_byte(r.name, r.data, rd_data);
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: the run timed out after %0d cycles", cycle_count);
            stop_on_failure();
        end
    end

    initial begin
        logic [7:0] cmd_byte;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = OP_NOP;
        cmd_data  = '0;
        credits   = QUEUE_DEPTH;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // Idle core, entry 0 is unwritten so only the offset is known
        repeat (4) begin
            @(negedge clock);
            expect_low("idle_credit", credit_return);
            expect_low("idle_bus_we", bus_we);
            expect_low("idle_rd_valid", rd_valid);
            check_addr("idle_addr", '0, {{PHYS_PAGE_W{1'b0}}, bus_addr[PAGE_OFFSET_W-1:0]});
        end
        @(posedge clock);

        for (int i = 0; i < NUM_VECTORS; i++) begin
            while (credits == 0) begin
                cmd_valid <= 1'b0; // Out of credits
                @(posedge clock);
            end
            cmd_byte = vectors[i].data;
            if (vectors[i].rnd_pte) begin
                random_pte(cmd_byte);
            end
            cmd_valid <= 1'b1;
            cmd_op    <= vectors[i].op;
            cmd_data  <= cmd_byte;
            credits   = credits - 1;
            sent      = sent + 1;
            apply_model(i, cmd_byte);
            @(posedge clock);
        end
        cmd_valid <= 1'b0;
        cmd_op    <= OP_NOP;

        // Drain bus pipeline
        while (write_q.size() != 0 || read_q.size() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock); // Late credits and stray pulses show up here
        compare_credits("credit_total", sent, returned);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
src/cmd_pkg.sv
src/mmu_pkg.sv
src/cmd_queue.sv
src/page_translator.sv
src/access_sequencer.sv
src/bus_port.sv
src/cpu6_mmu.sv
tests/tb_cpu6_mmu.sv
